// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                dcache_req_valid,
    input  logic                dcache_req_urgent,
    input  logic                dcache_req_store,
    input  mem_pkg::addr_t      dcache_req_addr,
    input  mem_pkg::block_t     dcache_req_data,
    input  logic                icache_req_valid,
    input  logic                icache_req_urgent,
    input  mem_pkg::addr_t      icache_req_addr,
    input  mem_pkg::mem_tag_t   mem2proc_transaction_tag,
    output logic                dcache_req_accepted,
    output logic                icache_req_accepted,
    output mem_pkg::mem_cmd_e   proc2mem_command,
    output mem_pkg::addr_t      proc2mem_addr,
    output mem_pkg::block_t     proc2mem_data,
    tag_table_if.arbiter        tag_table
);

    logic dcache_grant;
    logic icache_grant;
    logic tag_ok;

    // Fixed order: urgent D, urgent I, normal D, normal I.
    always_comb begin
        dcache_grant = 1'b0;
        icache_grant = 1'b0;
        if (dcache_req_valid && dcache_req_urgent) begin
            dcache_grant = 1'b1;
        end else if (icache_req_valid && icache_req_urgent) begin
            icache_grant = 1'b1;
        end else if (dcache_req_valid) begin
            dcache_grant = 1'b1;
        end else if (icache_req_valid) begin
            icache_grant = 1'b1;
        end
    end

    always_comb begin
        proc2mem_command = mem_pkg::CMD_NONE;
        proc2mem_addr    = '0;
        proc2mem_data    = '0;
        if (dcache_grant) begin
            proc2mem_addr = dcache_req_addr;
            if (dcache_req_store) begin
                proc2mem_command = mem_pkg::CMD_STORE;
                proc2mem_data    = dcache_req_data;
            end else begin
                proc2mem_command = mem_pkg::CMD_LOAD;
            end
        end else if (icache_grant) begin
            proc2mem_command = mem_pkg::CMD_LOAD;
            proc2mem_addr    = icache_req_addr;
        end
    end

    assign tag_ok = (mem2proc_transaction_tag != '0); // Zero tag is a refusal.

    assign dcache_req_accepted = dcache_grant && tag_ok;
    assign icache_req_accepted = icache_grant && tag_ok;

    // Only loads need a slot to route the returning block.
    assign tag_table.alloc_valid = icache_req_accepted ||
                                   (dcache_req_accepted && !dcache_req_store);
    assign tag_table.alloc_tag   = mem2proc_transaction_tag;
    assign tag_table.alloc_owner = dcache_grant ? mem_pkg::OWNER_DCACHE
                                                : mem_pkg::OWNER_ICACHE;

endmodule

`default_nettype wire

// ==== design/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int ADDR_BITS  = 32;
    localparam int BLOCK_BITS = 64;
    localparam int TAG_BITS   = 4;

    // Tags 1 to 15 are live; tag 0 means no transaction.
    localparam int NUM_TAGS = 16;

    typedef logic [ADDR_BITS-1:0]  addr_t;  // Byte address.
    typedef logic [BLOCK_BITS-1:0] block_t; // One memory block.
    typedef logic [TAG_BITS-1:0]   mem_tag_t;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_LOAD,
        CMD_STORE
    } mem_cmd_e;

    typedef enum logic {
        OWNER_ICACHE,
        OWNER_DCACHE
    } owner_e;

endpackage

`default_nettype wire

// ==== design/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  logic                clock,
    input  logic                rst,

    input  logic                dcache_req_valid,
    input  logic                dcache_req_urgent,
    input  logic                dcache_req_store,
    input  mem_pkg::addr_t      dcache_req_addr,
    input  mem_pkg::block_t     dcache_req_data,
    output logic                dcache_req_accepted,

    input  logic                icache_req_valid,
    input  logic                icache_req_urgent,
    input  mem_pkg::addr_t      icache_req_addr,
    output logic                icache_req_accepted,

    output mem_pkg::mem_cmd_e   proc2mem_command,
    output mem_pkg::addr_t      proc2mem_addr,
    output mem_pkg::block_t     proc2mem_data,
    input  mem_pkg::mem_tag_t   mem2proc_transaction_tag,
    input  mem_pkg::block_t     mem2proc_data,
    input  mem_pkg::mem_tag_t   mem2proc_data_tag,

    output logic                dcache_resp_valid,
    output mem_pkg::mem_tag_t   dcache_resp_tag,
    output logic                icache_resp_valid,
    output mem_pkg::mem_tag_t   icache_resp_tag,
    output mem_pkg::block_t     resp_data,

    output logic                orphan_response
);

    tag_table_if tag_table ();

    mem_arbiter u_arbiter (
        .dcache_req_valid         (dcache_req_valid),
        .dcache_req_urgent        (dcache_req_urgent),
        .dcache_req_store         (dcache_req_store),
        .dcache_req_addr          (dcache_req_addr),
        .dcache_req_data          (dcache_req_data),
        .icache_req_valid         (icache_req_valid),
        .icache_req_urgent        (icache_req_urgent),
        .icache_req_addr          (icache_req_addr),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .dcache_req_accepted      (dcache_req_accepted),
        .icache_req_accepted      (icache_req_accepted),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .tag_table                (tag_table.arbiter)
    );

    // Tag 0 never holds a transaction.
    assign tag_table.slot_valid[0] = 1'b0;
    assign tag_table.slot_owner[0] = mem_pkg::OWNER_ICACHE;

    for (genvar t = 1; t < mem_pkg::NUM_TAGS; t++) begin : g_slot
        tag_slot #(
            .SLOT_TAG (t)
        ) u_slot (
            .clock     (clock),
            .rst       (rst),
            .tag_table (tag_table.slot)
        );
    end

    response_router u_router (
        .clock             (clock),
        .rst               (rst),
        .mem2proc_data_tag (mem2proc_data_tag),
        .mem2proc_data     (mem2proc_data),
        .dcache_resp_valid (dcache_resp_valid),
        .icache_resp_valid (icache_resp_valid),
        .orphan_response   (orphan_response),
        .dcache_resp_tag   (dcache_resp_tag),
        .icache_resp_tag   (icache_resp_tag),
        .resp_data         (resp_data),
        .tag_table         (tag_table.router)
    );

endmodule

`default_nettype wire

// ==== design/response_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module response_router (
    input  logic                clock,
    input  logic                rst,
    input  mem_pkg::mem_tag_t   mem2proc_data_tag,
    input  mem_pkg::block_t     mem2proc_data,
    output logic                dcache_resp_valid,
    output logic                icache_resp_valid,
    output logic                orphan_response,
    output mem_pkg::mem_tag_t   dcache_resp_tag,
    output mem_pkg::mem_tag_t   icache_resp_tag,
    output mem_pkg::block_t     resp_data,
    tag_table_if.router         tag_table
);

    logic              data_present;
    logic              slot_live;
    mem_pkg::owner_e   slot_owner;
    mem_pkg::mem_tag_t resp_tag;

    assign data_present = (mem2proc_data_tag != '0);
    assign slot_live    = tag_table.slot_valid[mem2proc_data_tag];
    assign slot_owner   = tag_table.slot_owner[mem2proc_data_tag];

    // Slot is released at the same edge that launches the response.
    assign tag_table.free_valid = data_present && slot_live;
    assign tag_table.free_tag   = mem2proc_data_tag;

    always_ff @(posedge clock) begin
        if (rst) begin
            dcache_resp_valid <= 1'b0;
            icache_resp_valid <= 1'b0;
            orphan_response   <= 1'b0;
        end else begin
            dcache_resp_valid <= data_present && slot_live &&
                                 (slot_owner == mem_pkg::OWNER_DCACHE);
            icache_resp_valid <= data_present && slot_live &&
                                 (slot_owner == mem_pkg::OWNER_ICACHE);
            orphan_response   <= data_present && !slot_live; // Nobody asked for it.
        end
    end

    always_ff @(posedge clock) begin
        resp_data <= mem2proc_data;
        resp_tag  <= mem2proc_data_tag;
    end

    // Both caches see the same tag, qualified by their own valid.
    assign dcache_resp_tag = resp_tag;
    assign icache_resp_tag = resp_tag;

endmodule

`default_nettype wire

// ==== design/tag_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_slot #(
    parameter int SLOT_TAG = 1
) (
    input  logic      clock,
    input  logic      rst,
    tag_table_if.slot tag_table
);

    logic            valid;
    mem_pkg::owner_e owner;
    logic            alloc_hit;
    logic            free_hit;

    assign alloc_hit = tag_table.alloc_valid &&
                       (tag_table.alloc_tag == mem_pkg::mem_tag_t'(SLOT_TAG));
    assign free_hit  = tag_table.free_valid &&
                       (tag_table.free_tag == mem_pkg::mem_tag_t'(SLOT_TAG));

    always_ff @(posedge clock) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (alloc_hit) begin
            valid <= 1'b1;  // Allocation wins over a same-edge free.
        end else if (free_hit) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_hit) begin
            owner <= tag_table.alloc_owner;
        end
    end

    assign tag_table.slot_valid[SLOT_TAG] = valid;
    assign tag_table.slot_owner[SLOT_TAG] = owner;

endmodule

`default_nettype wire

// ==== design/tag_table_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface tag_table_if;

    logic                alloc_valid;
    mem_pkg::mem_tag_t   alloc_tag;
    mem_pkg::owner_e     alloc_owner;

    logic                free_valid;
    mem_pkg::mem_tag_t   free_tag;

    // One entry per tag, entry 0 stays invalid.
    logic [mem_pkg::NUM_TAGS-1:0] slot_valid;
    mem_pkg::owner_e              slot_owner [mem_pkg::NUM_TAGS];

    modport arbiter (
        output alloc_valid, alloc_tag, alloc_owner
    );

    modport slot (
        input  alloc_valid, alloc_tag, alloc_owner, free_valid, free_tag,
        output slot_valid, slot_owner
    );

    modport router (
        input  slot_valid, slot_owner,
        output free_valid, free_tag
    );

endinterface

`default_nettype wire

// ==== flist.f ====
design/mem_pkg.sv
design/tag_table_if.sv
design/mem_arbiter.sv
design/tag_slot.sv
design/response_router.sv
design/mem_subsystem.sv
test/mem_subsystem_assert.sv
test/mem_subsystem_tb.sv

// ==== test/mem_subsystem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_assert (
    input logic              clock,
    input logic              rst,
    input logic              dcache_req_valid, dcache_req_urgent, dcache_req_store,
    input mem_pkg::addr_t    dcache_req_addr,
    input mem_pkg::block_t   dcache_req_data,
    input logic              icache_req_valid, icache_req_urgent,
    input mem_pkg::addr_t    icache_req_addr,
    input logic              dcache_req_accepted, icache_req_accepted,
    input mem_pkg::mem_cmd_e proc2mem_command,
    input mem_pkg::addr_t    proc2mem_addr,
    input mem_pkg::block_t   proc2mem_data,
    input mem_pkg::mem_tag_t mem2proc_transaction_tag, mem2proc_data_tag,
    input mem_pkg::block_t   mem2proc_data,
    input logic              dcache_resp_valid, icache_resp_valid, orphan_response,
    input mem_pkg::mem_tag_t dcache_resp_tag, icache_resp_tag,
    input mem_pkg::block_t   resp_data
);

    int error_count = 0;

    logic                         d_wins;
    logic                         i_wins;
    mem_pkg::mem_cmd_e            exp_cmd;
    mem_pkg::addr_t               exp_addr;
    mem_pkg::block_t              exp_wdata;
    logic [mem_pkg::NUM_TAGS-1:0] shadow_valid;
    logic [mem_pkg::NUM_TAGS-1:0] shadow_dcache; // Owner is the data cache.
    logic                         load_acc;
    logic                         ret_live;
    logic                         exp_dresp;
    logic                         exp_iresp;
    logic                         exp_orphan;
    mem_pkg::mem_tag_t            exp_tag;
    mem_pkg::block_t              exp_rdata;

    // D wins when urgent, or when normal and no urgent I is waiting.
    assign d_wins = dcache_req_valid &&
                    (dcache_req_urgent || !(icache_req_valid && icache_req_urgent));
    assign i_wins = icache_req_valid && !d_wins;

    always_comb begin
        exp_cmd   = mem_pkg::CMD_NONE;
        exp_addr  = '0;
        exp_wdata = '0;
        if (d_wins) begin
            exp_cmd   = dcache_req_store ? mem_pkg::CMD_STORE : mem_pkg::CMD_LOAD;
            exp_addr  = dcache_req_addr;
            exp_wdata = dcache_req_store ? dcache_req_data : '0;
        end else if (i_wins) begin
            exp_cmd  = mem_pkg::CMD_LOAD;
            exp_addr = icache_req_addr;
        end
    end

    assign load_acc = icache_req_accepted || (dcache_req_accepted && !dcache_req_store);
    assign ret_live = (mem2proc_data_tag != '0) && shadow_valid[mem2proc_data_tag];

    always_ff @(posedge clock) begin
        exp_tag   <= mem2proc_data_tag;
        exp_rdata <= mem2proc_data;
        if (rst) begin
            shadow_valid <= '0;
            exp_dresp    <= 1'b0;
            exp_iresp    <= 1'b0;
            exp_orphan   <= 1'b0;
        end else begin
            exp_dresp  <= ret_live && shadow_dcache[mem2proc_data_tag];
            exp_iresp  <= ret_live && !shadow_dcache[mem2proc_data_tag];
            exp_orphan <= (mem2proc_data_tag != '0) && !ret_live;
            if (ret_live) begin
                shadow_valid[mem2proc_data_tag] <= 1'b0;
            end
            if (load_acc) begin
                shadow_valid[mem2proc_transaction_tag]  <= 1'b1; // Beats a same-edge free.
                shadow_dcache[mem2proc_transaction_tag] <= dcache_req_accepted;
            end
        end
    end

    a_command: assert property (@(posedge clock) disable iff (rst)
        proc2mem_command == exp_cmd)
    else begin
        error_count++;
        $error("Fail proc2mem_command exp %h got %h", $sampled(exp_cmd),
               $sampled(proc2mem_command));
    end

    a_addr: assert property (@(posedge clock) disable iff (rst) proc2mem_addr == exp_addr)
    else begin
        error_count++;
        $error("Fail proc2mem_addr exp %h got %h", $sampled(exp_addr), $sampled(proc2mem_addr));
    end

    a_wdata: assert property (@(posedge clock) disable iff (rst) proc2mem_data == exp_wdata)
    else begin
        error_count++;
        $error("Fail proc2mem_data exp %h got %h", $sampled(exp_wdata), $sampled(proc2mem_data));
    end

    // A zero tag is a refusal, so nobody is accepted.
    a_accept: assert property (@(posedge clock) disable iff (rst)
        {dcache_req_accepted, icache_req_accepted} ==
        ({d_wins, i_wins} & {2{mem2proc_transaction_tag != '0}}))
    else begin
        error_count++;
        $error("Fail dcache_req_accepted/icache_req_accepted exp %h got %h",
               $sampled({d_wins, i_wins} & {2{mem2proc_transaction_tag != '0}}),
               $sampled({dcache_req_accepted, icache_req_accepted}));
    end

    a_route: assert property (@(posedge clock) disable iff (rst)
        {dcache_resp_valid, icache_resp_valid, orphan_response} ==
        {exp_dresp, exp_iresp, exp_orphan})
    else begin
        error_count++;
        $error("Fail dcache_resp_valid/icache_resp_valid/orphan_response exp %h got %h",
               $sampled({exp_dresp, exp_iresp, exp_orphan}),
               $sampled({dcache_resp_valid, icache_resp_valid, orphan_response}));
    end

    a_payload: assert property (@(posedge clock) disable iff (rst)
        (dcache_resp_valid || icache_resp_valid) |->
        ((dcache_resp_valid ? dcache_resp_tag : icache_resp_tag) == exp_tag &&
         resp_data == exp_rdata))
    else begin
        error_count++;
        $error("Fail resp_tag/resp_data exp %h %h got %h %h", $sampled(exp_tag),
               $sampled(exp_rdata), $sampled(dcache_resp_tag), $sampled(resp_data));
    end

    a_reset_quiet: assert property (@(posedge clock)
        $past(rst) |-> !(dcache_resp_valid || icache_resp_valid || orphan_response))
    else begin
        error_count++;
        $error("A response or orphan pulse appeared during or right after reset");
    end

endmodule

`default_nettype wire

// ==== test/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int IDLE_CYCLES   = 8;
    localparam int PRIO_CYCLES   = 400;
    localparam int BP_CYCLES     = 300;
    localparam int OOO_CYCLES    = 600;
    localparam int ORPHAN_CYCLES = 300;
    localparam int DRAIN_CYCLES  = 40;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + PRIO_CYCLES + BP_CYCLES +
                                   OOO_CYCLES + ORPHAN_CYCLES + DRAIN_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'h16a8_f578;

    logic              clock;
    logic              rst;
    logic              dcache_req_valid;
    logic              dcache_req_urgent;
    logic              dcache_req_store;
    mem_pkg::addr_t    dcache_req_addr;
    mem_pkg::block_t   dcache_req_data;
    logic              dcache_req_accepted;
    logic              icache_req_valid;
    logic              icache_req_urgent;
    mem_pkg::addr_t    icache_req_addr;
    logic              icache_req_accepted;
    mem_pkg::mem_cmd_e proc2mem_command;
    mem_pkg::addr_t    proc2mem_addr;
    mem_pkg::block_t   proc2mem_data;
    mem_pkg::mem_tag_t mem2proc_transaction_tag;
    mem_pkg::block_t   mem2proc_data;
    mem_pkg::mem_tag_t mem2proc_data_tag;
    logic              dcache_resp_valid;
    mem_pkg::mem_tag_t dcache_resp_tag;
    logic              icache_resp_valid;
    mem_pkg::mem_tag_t icache_resp_tag;
    mem_pkg::block_t   resp_data;
    logic              orphan_response;

    // Behavioral memory state.
    logic                         busy;
    mem_pkg::mem_tag_t            ptr;      // Next tag to hand out.
    mem_pkg::mem_tag_t            free_tag;
    logic [mem_pkg::NUM_TAGS-1:0] outstanding;
    mem_pkg::addr_t               pend_addr [mem_pkg::NUM_TAGS];
    int                           due [mem_pkg::NUM_TAGS];

    logic [31:0] lfsr;
    int          cycle;
    int          reported_errors;
    int          tests_run;
    int          tests_failed;

    mem_subsystem u_mem_subsystem (.*);

    bind mem_subsystem mem_subsystem_assert u_assert (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // First tag at or after ptr that is not in flight, rotating over 1 to 15.
    always_comb begin
        int cand;
        free_tag = '0;
        for (int i = mem_pkg::NUM_TAGS - 2; i >= 0; i--) begin
            cand = (int'(ptr) - 1 + i) % (mem_pkg::NUM_TAGS - 1) + 1;
            if (!outstanding[cand]) free_tag = mem_pkg::mem_tag_t'(cand);
        end
    end

    assign mem2proc_transaction_tag =
        (proc2mem_command != mem_pkg::CMD_NONE && !busy) ? free_tag : '0;

    task automatic step_cycle(input int req_odds, input int busy_odds,
                              input bit stores, input bit orphans);
        mem_pkg::mem_tag_t acc_tag;
        mem_pkg::mem_tag_t ret_tag;
        mem_pkg::mem_tag_t orphan_tag;
        int                start;
        int                cand;
        @(posedge clock);
        cycle++;
        acc_tag = (dcache_req_accepted || icache_req_accepted) ? mem2proc_transaction_tag : '0;
        if (acc_tag != '0) begin
            ptr <= mem_pkg::mem_tag_t'(int'(acc_tag) % (mem_pkg::NUM_TAGS - 1) + 1);
        end
        if (acc_tag != '0 && proc2mem_command == mem_pkg::CMD_LOAD) begin
            outstanding[acc_tag] <= 1'b1;
            pend_addr[acc_tag]   = proc2mem_addr;
            due[acc_tag]         = cycle + int'(rand_bits(4)); // Random return delay.
        end
        ret_tag    = '0;
        orphan_tag = '0;
        start      = int'(rand_bits(4));
        for (int i = 0; i < mem_pkg::NUM_TAGS - 1; i++) begin
            cand = (start + i) % (mem_pkg::NUM_TAGS - 1) + 1;
            if (ret_tag == '0 && outstanding[cand] && due[cand] <= cycle) begin
                ret_tag = mem_pkg::mem_tag_t'(cand);
            end
            if (orphan_tag == '0 && !outstanding[cand] && cand != int'(acc_tag)) begin
                orphan_tag = mem_pkg::mem_tag_t'(cand);
            end
        end
        if (orphans && rand_bits(3) == 0) begin
            mem2proc_data_tag <= orphan_tag;
            mem2proc_data     <= {lfsr, ~lfsr};
        end else if (ret_tag != '0) begin
            outstanding[ret_tag] <= 1'b0;
            mem2proc_data_tag    <= ret_tag;
            mem2proc_data        <= {pend_addr[ret_tag], pend_addr[ret_tag]};
        end else begin
            mem2proc_data_tag <= '0;
        end
        // A cache keeps its request until it is accepted.
        if (!dcache_req_valid || dcache_req_accepted) begin
            dcache_req_valid  <= rand_bits(2) < req_odds;
            dcache_req_urgent <= rand_bits(1) == 1;
            dcache_req_store  <= stores && rand_bits(2) == 0;
            dcache_req_addr   <= rand_bits(28) << 4;
            dcache_req_data   <= {rand_bits(32), rand_bits(32)};
        end
        if (!icache_req_valid || icache_req_accepted) begin
            icache_req_valid  <= rand_bits(2) < req_odds;
            icache_req_urgent <= rand_bits(1) == 1;
            icache_req_addr   <= rand_bits(28) << 4;
        end
        busy <= rand_bits(2) < busy_odds;
    endtask

    task automatic run_test(input string name, input int cycles, input int req_odds,
                            input int busy_odds, input bit stores, input bit orphans);
        int errors;
        repeat (cycles) step_cycle(req_odds, busy_odds, stores, orphans);
        @(negedge clock);
        errors          = u_mem_subsystem.u_assert.error_count - reported_errors;
        reported_errors = u_mem_subsystem.u_assert.error_count;
        tests_run++;
        if (errors == 0) begin
            $display("Test %s passed after %0d cycles", name, cycles);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d assertion errors", name, errors);
        end
    endtask

    initial begin
        lfsr              = LFSR_SEED;
        cycle             = 0;
        reported_errors   = 0;
        tests_run         = 0;
        tests_failed      = 0;
        rst               <= 1'b1;
        dcache_req_valid  <= 1'b0;
        dcache_req_urgent <= 1'b0;
        dcache_req_store  <= 1'b0;
        dcache_req_addr   <= '0;
        dcache_req_data   <= '0;
        icache_req_valid  <= 1'b0;
        icache_req_urgent <= 1'b0;
        icache_req_addr   <= '0;
        mem2proc_data     <= '0;
        mem2proc_data_tag <= '0;
        busy              <= 1'b0;
        ptr               <= 4'd1;
        outstanding       <= '0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b0;
        run_test("reset", IDLE_CYCLES, 0, 0, 1'b0, 1'b0);
        run_test("priority", PRIO_CYCLES, 3, 0, 1'b1, 1'b0);
        run_test("backpressure", BP_CYCLES, 3, 3, 1'b1, 1'b0);
        run_test("out_of_order", OOO_CYCLES, 3, 1, 1'b0, 1'b0);
        run_test("orphan", ORPHAN_CYCLES, 2, 1, 1'b0, 1'b1);
        run_test("drain", DRAIN_CYCLES, 0, 0, 1'b0, 1'b0); // Lets every load come back.
        $display("Tests run %0d, failed %0d, assertion errors %0d", tests_run, tests_failed,
                 reported_errors);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 TOTAL_CYCLES * 4);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
